// File: car_dispatch.sv
`timescale 1ns/1ps

module car_dispatch import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  car_state_t  elevator_state,
    input  floor_t      current_floor,
    input  logic        power_switch,
    input  logic        emergency_btn,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  floor_t      top,
    input  logic        empty,
    output car_status_t status,
    output logic        flush,
    output logic        pop,
    output floor_t      floor_selector,
    output logic        direction,
    output logic        activate,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    logic stopped;
    logic at_top;

    //////////////////////////////
    // Car status
    //////////////////////////////

    assign stopped = is_stop_state(elevator_state);

    always_comb begin
        status.stopped = stopped;
        status.floor   = current_floor;
    end

    // Lost power or emergency wipes every request
    assign flush = !power_switch || emergency_btn;

    // Car already stands at the newest request
    assign at_top = stopped && !empty && (top == current_floor);

    // Served entry leaves the stack at the next edge
    assign pop = at_top && !flush;

    //////////////////////////////
    // Target registers
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            floor_selector <= '0;
            direction      <= DIR_UP;
            activate       <= 1'b0;
        end else if (emergency_btn) begin
            floor_selector <= SELECT_EMERGENCY;
            direction      <= DIR_UP;
            activate       <= 1'b0;
        end else if (!power_switch) begin
            activate <= 1'b0;
        end else if (stopped && !empty) begin
            if (at_top) begin
                activate <= 1'b0;
            end else begin
                floor_selector <= top;
                activate       <= 1'b1;
                direction      <= (top > current_floor) ? DIR_UP : DIR_DOWN;
            end
        end else begin
            // Selector keeps the last target
            activate <= 1'b0;
        end
    end

    //////////////////////////////
    // Door permits
    //////////////////////////////

    always_comb begin
        door_open_allowed  = stopped && power_switch && door_open_btn;
        door_close_allowed = stopped && power_switch && door_close_btn;
    end

endmodule

// File: elevator_pkg.sv
package elevator_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int NUM_FLOORS  = 11;
    localparam int STACK_DEPTH = 11;

    // Pointer counts entries, so it must reach STACK_DEPTH itself
    localparam int STACK_PTR_W = $clog2(STACK_DEPTH + 1);

    //////////////////////////////
    // Vector types
    //////////////////////////////

    // Floor number, 0 is the ground floor
    typedef logic [3:0] floor_t;

    // One bit per floor, bit 0 is the ground floor
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // State code of the car FSM
    typedef logic [5:0] car_state_t;

    // Number of entries held in the floor stack
    typedef logic [STACK_PTR_W-1:0] stack_ptr_t;

    //////////////////////////////
    // Codes
    //////////////////////////////

    // Stop states occupy codes 0 up to this one, one per floor
    localparam car_state_t STATE_STOP_LAST = car_state_t'(NUM_FLOORS - 1);

    // Selector value shown while emergency is active
    localparam floor_t SELECT_EMERGENCY = 4'hF;

    localparam logic DIR_UP   = 1'b1;
    localparam logic DIR_DOWN = 1'b0;

    //////////////////////////////
    // Structs
    //////////////////////////////

    // One push request, from a latch or into the stack
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_req_t;

    // Where the car is and whether it stands still
    typedef struct packed {
        logic   stopped;
        floor_t floor;
    } car_status_t;

    // Codes 0 to 10 are the stop states
    function automatic logic is_stop_state(input car_state_t state);
        return state <= STATE_STOP_LAST;
    endfunction

endpackage

// File: filelist.f
+incdir+.
elevator_pkg.sv
request_latch.sv
push_arbiter.sv
floor_stack.sv
car_dispatch.sv
floor_logic_top.sv
tb_floor_logic.sv

// File: floor_logic_top.sv
`timescale 1ns/1ps

module floor_logic_top import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  floor_t      current_floor_state,
    input  car_state_t  elevator_state,
    output floor_t      elevator_floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights
);

    car_status_t status;
    logic        flush;
    logic        pop;

    floor_req_t  panel_req;
    floor_req_t  hall_req;
    floor_req_t  push;
    logic        panel_grant;
    logic        hall_grant;

    floor_t      top;
    logic        empty;
    logic        full;

    //////////////////////////////
    // Request latches
    //////////////////////////////

    request_latch u_panel_latch (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (panel_buttons),
        .status  (status),
        .flush   (flush),
        .grant   (panel_grant),
        .lights  (panel_button_lights),
        .req     (panel_req)
    );

    request_latch u_hall_latch (
        .clock   (clock),
        .reset_n (reset_n),
        .buttons (floor_call_buttons),
        .status  (status),
        .flush   (flush),
        .grant   (hall_grant),
        .lights  (call_button_lights),
        .req     (hall_req)
    );

    //////////////////////////////
    // Stack access
    //////////////////////////////

    push_arbiter u_push_arbiter (
        .clock       (clock),
        .reset_n     (reset_n),
        .panel_req   (panel_req),
        .hall_req    (hall_req),
        .full        (full),
        .panel_grant (panel_grant),
        .hall_grant  (hall_grant),
        .push        (push)
    );

    floor_stack u_floor_stack (
        .clock   (clock),
        .reset_n (reset_n),
        .push    (push),
        .pop     (pop),
        .flush   (flush),
        .top     (top),
        .empty   (empty),
        .full    (full)
    );

    //////////////////////////////
    // Dispatcher
    //////////////////////////////

    car_dispatch u_car_dispatch (
        .clock              (clock),
        .reset_n            (reset_n),
        .elevator_state     (elevator_state),
        .current_floor      (current_floor_state),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .top                (top),
        .empty              (empty),
        .status             (status),
        .flush              (flush),
        .pop                (pop),
        .floor_selector     (elevator_floor_selector),
        .direction          (direction_selector),
        .activate           (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: floor_stack.sv
`timescale 1ns/1ps

module floor_stack import elevator_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  floor_req_t push,
    input  logic       pop,
    input  logic       flush,
    output floor_t     top,
    output logic       empty,
    output logic       full
);

    localparam stack_ptr_t PTR_FULL = stack_ptr_t'(STACK_DEPTH);

    floor_t     entries [STACK_DEPTH];
    stack_ptr_t ptr;

    logic do_pop;
    logic do_push;

    assign empty = (ptr == '0);
    assign full  = (ptr == PTR_FULL);

    // Most recent entry sits just below the pointer
    assign top = empty ? floor_t'(0) : entries[ptr - 1'b1];

    //////////////////////////////
    // Operation select
    //////////////////////////////

    // Flush cancels both, pop on an empty stack is ignored
    assign do_pop  = !flush && pop && !empty;
    assign do_push = !flush && push.valid && (do_pop || !full);

    //////////////////////////////
    // Pointer
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (flush) begin
            ptr <= '0;
        end else if (do_pop) begin
            // A push in the same cycle refills the popped slot
            if (!do_push) begin
                ptr <= ptr - 1'b1;
            end
        end else if (do_push) begin
            ptr <= ptr + 1'b1;
        end
    end

    //////////////////////////////
    // Entry storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            if (do_pop) begin
                entries[ptr - 1'b1] <= push.floor;
            end else begin
                entries[ptr] <= push.floor;
            end
        end
    end

endmodule

// File: push_arbiter.sv
`timescale 1ns/1ps

module push_arbiter import elevator_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  floor_req_t panel_req,
    input  floor_req_t hall_req,
    input  logic       full,
    output logic       panel_grant,
    output logic       hall_grant,
    output floor_req_t push
);

    // Set after a panel grant, so the hall side wins the next tie
    logic favor_hall;

    //////////////////////////////
    // Grant decision
    //////////////////////////////

    always_comb begin
        panel_grant = 1'b0;
        hall_grant  = 1'b0;
        if (!full) begin
            if (panel_req.valid && hall_req.valid) begin
                hall_grant  = favor_hall;
                panel_grant = !favor_hall;
            end else begin
                panel_grant = panel_req.valid;
                hall_grant  = hall_req.valid;
            end
        end
    end

    // Granted request goes straight into the stack
    always_comb begin
        push.valid = panel_grant | hall_grant;
        push.floor = hall_grant ? hall_req.floor : panel_req.floor;
    end

    //////////////////////////////
    // Last winner
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            favor_hall <= 1'b0;
        end else if (panel_grant) begin
            favor_hall <= 1'b1;
        end else if (hall_grant) begin
            favor_hall <= 1'b0;
        end
    end

endmodule

// File: request_latch.sv
`timescale 1ns/1ps

module request_latch import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t buttons,
    input  car_status_t status,
    input  logic        flush,
    input  logic        grant,
    output floor_mask_t lights,
    output floor_req_t  req
);

    // Floors lit but not yet handed to the stack
    floor_mask_t pending;

    floor_mask_t here_mask;
    floor_mask_t grant_mask;
    floor_mask_t new_mask;

    //////////////////////////////
    // Masks for this cycle
    //////////////////////////////

    always_comb begin
        here_mask = '0;
        if (status.stopped && (status.floor < NUM_FLOORS)) begin
            here_mask[status.floor] = 1'b1;
        end
    end

    always_comb begin
        grant_mask = '0;
        if (grant && req.valid && (req.floor < NUM_FLOORS)) begin
            grant_mask[req.floor] = 1'b1;
        end
    end

    // A press counts once, and never for the floor the car stands at
    assign new_mask = buttons & ~lights & ~here_mask;

    //////////////////////////////
    // Light and pending registers
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights  <= '0;
            pending <= '0;
        end else if (flush) begin
            lights  <= '0;
            pending <= '0;
        end else begin
            lights  <= (lights | new_mask) & ~here_mask;
            pending <= (pending | new_mask) & ~here_mask & ~grant_mask;
        end
    end

    // Offer the lowest pending floor, held until granted
    always_comb begin
        req.valid = |pending;
        req.floor = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                req.floor = floor_t'(i);
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the floor logic testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_floor_logic \
    -o tb_floor_logic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_floor_logic_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb_floor_model.svh
`ifndef TB_FLOOR_MODEL_SVH
`define TB_FLOOR_MODEL_SVH

// Reference model, newest stack entry at the back of the queue
floor_t      model_stack[$];
floor_mask_t model_panel_lights;
floor_mask_t model_hall_lights;
logic        model_favor_hall;

function automatic floor_mask_t floor_bit(input floor_t floor);
    floor_mask_t mask;
    mask        = '0;
    mask[floor] = 1'b1;
    return mask;
endfunction

function automatic logic expected_direction(input floor_t target, input floor_t here);
    return (target > here) ? DIR_UP : DIR_DOWN;
endfunction

function automatic logic expected_door(input logic button, input logic stopped,
                                       input logic power);
    return button && stopped && power;
endfunction

// New lights and pushes of one press, lowest floor of each side first
function automatic void model_press(input floor_mask_t panel, input floor_mask_t hall,
                                    input logic stopped, input floor_t here);
    floor_t      panel_new[$];
    floor_t      hall_new[$];
    floor_mask_t refused;
    refused = stopped ? floor_bit(here) : '0;
    for (int i = 0; i < NUM_FLOORS; i++) begin
        if (panel[i] && !model_panel_lights[i] && !refused[i]) begin
            panel_new.push_back(floor_t'(i));
        end
        if (hall[i] && !model_hall_lights[i] && !refused[i]) begin
            hall_new.push_back(floor_t'(i));
        end
    end
    model_panel_lights = model_panel_lights | (panel & ~refused);
    model_hall_lights  = model_hall_lights | (hall & ~refused);
    // On a tie the side that lost last time goes first
    while (panel_new.size() > 0 || hall_new.size() > 0) begin
        if (hall_new.size() > 0 && (panel_new.size() == 0 || model_favor_hall)) begin
            model_stack.push_back(hall_new.pop_front());
            model_favor_hall = 1'b0;
        end else begin
            model_stack.push_back(panel_new.pop_front());
            model_favor_hall = 1'b1;
        end
    end
endfunction

// Car stopped at a floor clears its lights and pops it while it is on top
function automatic void model_serve(input floor_t here);
    model_panel_lights = model_panel_lights & ~floor_bit(here);
    model_hall_lights  = model_hall_lights & ~floor_bit(here);
    while (model_stack.size() > 0 && model_stack[$] == here) begin
        void'(model_stack.pop_back());
    end
endfunction

function automatic void model_flush();
    model_stack.delete();
    model_panel_lights = '0;
    model_hall_lights  = '0;
endfunction

`endif

// File: tb_floor_logic.sv
`timescale 1ns/1ps

module tb_floor_logic import elevator_pkg::*; ();

    localparam int         CLOCK_PERIOD = 8;
    localparam car_state_t TRAVEL_STATE = 6'd20;
    // Cycle budget of the reset, press, single press, pair, serve, emergency and power sections
    localparam int TEST_CYCLES    = 6 + 10 + 25 + 15 + 12 + 10 + 15;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    car_state_t  elevator_state;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    int     seed = 32'h7c77;
    int     cycle_count = 0;
    event   compare_ev;
    logic   car_stopped;
    floor_t car_floor;
    floor_t exp_selector;
    logic   exp_direction;
    logic   exp_activate;

    `include "tb_floor_model.svh"

    floor_logic_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    //////////////////////////////
    // Compare process
    //////////////////////////////

    task automatic compare_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, actual,
                     expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    always @(compare_ev) begin
        compare_value("panel_button_lights", int'(panel_button_lights), int'(model_panel_lights));
        compare_value("call_button_lights", int'(call_button_lights), int'(model_hall_lights));
        compare_value("activate_elevator", int'(activate_elevator), int'(exp_activate));
        compare_value("elevator_floor_selector", int'(elevator_floor_selector),
                      int'(exp_selector));
        compare_value("direction_selector", int'(direction_selector), int'(exp_direction));
        compare_value("door_open_allowed", int'(door_open_allowed),
                      int'(expected_door(door_open_btn, car_stopped, power_switch)));
        compare_value("door_close_allowed", int'(door_close_allowed),
                      int'(expected_door(door_close_btn, car_stopped, power_switch)));
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic pick_free_floor(input floor_mask_t avoid, output floor_t floor);
        do begin
            floor = floor_t'($unsigned($random(seed)) % NUM_FLOORS);
        end while (avoid[floor]);
    endtask

    task automatic move_car(input logic stop, input floor_t floor);
        @(posedge clock);
        elevator_state      <= stop ? car_state_t'(floor) : TRAVEL_STATE;
        current_floor_state <= floor;
        car_stopped = stop;
        car_floor   = floor;
    endtask

    // Buttons are held for one cycle and the lights are up on return
    task automatic press(input floor_mask_t panel, input floor_mask_t hall);
        @(posedge clock);
        panel_buttons      <= panel;
        floor_call_buttons <= hall;
        @(posedge clock);
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
        model_press(panel, hall, car_stopped, car_floor);
    endtask

    task automatic compare_outputs();
        @(negedge clock);
        -> compare_ev;
    endtask

    task automatic wait_for_activate(input logic level);
        @(negedge clock);
        while (activate_elevator !== level) begin
            @(negedge clock);
        end
    endtask

    function automatic void expect_target();
        exp_selector  = model_stack[$];
        exp_direction = expected_direction(exp_selector, car_floor);
        exp_activate  = 1'b1;
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        floor_t      home;
        floor_t      pick;
        floor_t      hall_pick;
        floor_mask_t used;
        panel_buttons       = '0;
        floor_call_buttons  = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        elevator_state      = TRAVEL_STATE;
        current_floor_state = '0;
        car_stopped         = 1'b0;
        car_floor           = '0;
        model_panel_lights  = '0;
        model_hall_lights   = '0;
        model_favor_hall    = 1'b0;
        exp_selector        = '0;
        exp_direction       = DIR_UP;
        exp_activate        = 1'b0;
        reset_n             = 1'b0;
        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        compare_outputs();

        // Stopped at home, a press for home itself is refused
        pick_free_floor('0, home);
        move_car(1'b1, home);
        pick_free_floor(floor_bit(home), pick);
        press(floor_bit(pick) | floor_bit(home), '0);
        compare_outputs();
        wait_for_activate(1'b1);
        expect_target();
        -> compare_ev;

        // Single presses while travelling, then a stop
        move_car(1'b0, home);
        exp_activate = 1'b0;
        used = floor_bit(home) | model_panel_lights;
        repeat (3) begin
            pick_free_floor(used, pick);
            press(floor_bit(pick), '0);
            used = used | floor_bit(pick);
            repeat (3) @(posedge clock);
        end
        compare_outputs();
        move_car(1'b1, home);
        wait_for_activate(1'b1);
        expect_target();
        -> compare_ev;

        // Panel and hall presses in the same cycle
        move_car(1'b0, home);
        exp_activate = 1'b0;
        pick_free_floor(used, pick);
        pick_free_floor(model_hall_lights | floor_bit(home) | floor_bit(pick), hall_pick);
        press(floor_bit(pick), floor_bit(hall_pick));
        compare_outputs();
        repeat (3) @(posedge clock);
        move_car(1'b1, home);
        wait_for_activate(1'b1);
        expect_target();
        -> compare_ev;

        // Hall call for the selected floor too, then arrive there
        press('0, floor_bit(exp_selector));
        compare_outputs();
        move_car(1'b1, exp_selector);
        model_serve(car_floor);
        wait_for_activate(1'b0);
        wait_for_activate(1'b1);
        expect_target();
        -> compare_ev;

        // Emergency wipes everything and stays idle after release
        @(posedge clock);
        emergency_btn <= 1'b1;
        model_flush();
        exp_selector  = SELECT_EMERGENCY;
        exp_direction = DIR_UP;
        exp_activate  = 1'b0;
        @(posedge clock);
        compare_outputs();
        @(posedge clock);
        emergency_btn <= 1'b0;
        repeat (5) compare_outputs();

        // Door permits one button at a time, then power off during travel
        @(posedge clock);
        door_open_btn <= 1'b1;
        compare_outputs();
        @(posedge clock);
        door_close_btn <= 1'b1;
        compare_outputs();
        move_car(1'b0, car_floor);
        compare_outputs();
        pick_free_floor('0, pick);
        press(floor_bit(pick), floor_bit(pick));
        compare_outputs();
        @(posedge clock);
        power_switch <= 1'b0;
        model_flush();
        @(posedge clock);
        compare_outputs();
        move_car(1'b1, car_floor);
        compare_outputs();

        @(posedge clock);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
